//--- verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // serial frame layout
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 11;

  // host side widths
  localparam int CMD_WIDTH  = 16;
  localparam int READ_WIDTH = 8;

  // command word fields, where flag and address form the first byte on the line
  localparam int CMD_WR_BIT   = 15;
  localparam int CMD_ADDR_MSB = 14;
  localparam int CMD_ADDR_LSB = 8;

  // parity bit that makes the total number of ones even
  function automatic logic even_parity(input logic [DATA_BITS-1:0] byte_in);
    logic p;
    p = ^byte_in;
    return p;
  endfunction

endpackage

`default_nettype wire

//--- verilog/uart_tx_if.sv
`timescale 1ns/1ps
`default_nettype none

// one byte handed from the command sequencer to the serializer
interface uart_tx_if import uart_pkg::*; ();

  logic                 start;
  logic [DATA_BITS-1:0] data;
  logic                 busy;
  logic                 done;

  modport seq (
    output start,
    output data,
    input  busy,
    input  done
  );

  modport tx (
    input  start,
    input  data,
    output busy,
    output done
  );

endinterface

`default_nettype wire

//--- verilog/uart_rx_if.sv
`timescale 1ns/1ps
`default_nettype none

// received byte with its frame checks, judged by the sequencer
interface uart_rx_if import uart_pkg::*; ();

  logic                 valid;
  logic [DATA_BITS-1:0] data;
  logic                 parity_ok;
  logic                 stop_ok;

  modport rx (
    output valid,
    output data,
    output parity_ok,
    output stop_ok
  );

  modport seq (
    input valid,
    input data,
    input parity_ok,
    input stop_ok
  );

endinterface

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic  clk,
  input  logic  rst_n,
  uart_tx_if.tx tif,
  output logic  tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(FRAME_BITS);

  logic [CNT_W-1:0]        clk_cnt;
  logic [IDX_W-1:0]        bit_idx;
  logic [FRAME_BITS-2:0]   frame;
  logic                    busy;
  logic                    bit_end;
  logic                    last_bit;

  assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign last_bit = (bit_idx == IDX_W'(FRAME_BITS - 1));

  assign tif.busy = busy;
  assign tif.done = busy && bit_end && last_bit;

  // everything after the start bit, in line order: data lsb first, parity, stop
  always_ff @(posedge clk) begin
    if (tif.start && !busy) begin
      frame <= {1'b1, even_parity(tif.data), tif.data};
    end
  end

  // bit_idx counts line bits with the start bit as 0, so frame[bit_idx] is the next bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else if (!busy) begin
      if (tif.start) begin
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_idx <= '0;
        tx      <= 1'b0;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      if (last_bit) begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end else begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= frame[bit_idx];
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // the sequencer has to wait for the previous frame to finish
  start_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(tif.start && busy)
  );

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx,
  uart_rx_if.rx rif
);

  localparam int CNT_W    = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W    = $clog2(FRAME_BITS);
  localparam int HALF_END = (CLKS_PER_BIT / 2 > 0) ? CLKS_PER_BIT / 2 - 1 : 0;

  localparam logic [1:0] R_IDLE  = 2'd0;
  localparam logic [1:0] R_START = 2'd1;
  localparam logic [1:0] R_BITS  = 2'd2;

  logic [1:0]           state;
  logic [CNT_W-1:0]     clk_cnt;
  logic [IDX_W-1:0]     bit_idx;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic                 fall;
  logic                 bit_end;
  logic                 valid;
  logic [DATA_BITS-1:0] shreg;
  logic                 par_bit;
  logic                 stop_bit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall    = rx_prev && !rx_sync;
  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  // after the start check, bit_idx runs over 8 data bits, then parity, then stop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= R_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      valid   <= 1'b0;
    end else begin
      valid <= 1'b0;
      case (state)
        R_IDLE: begin
          if (fall) begin
            state   <= R_START;
            clk_cnt <= '0;
          end
        end
        R_START: begin
          if (clk_cnt == CNT_W'(HALF_END)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // a line that is high again at mid start bit was only a glitch
            state   <= rx_sync ? R_IDLE : R_BITS;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        R_BITS: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == IDX_W'(FRAME_BITS - 2)) begin
              state <= R_IDLE;
              valid <= 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == R_BITS && bit_end) begin
      if (bit_idx < IDX_W'(DATA_BITS)) begin
        shreg <= {rx_sync, shreg[DATA_BITS-1:1]};
      end else if (bit_idx == IDX_W'(DATA_BITS)) begin
        par_bit <= rx_sync;
      end else begin
        stop_bit <= rx_sync;
      end
    end
  end

  assign rif.valid     = valid;
  assign rif.data      = shreg;
  assign rif.parity_ok = (par_bit == even_parity(shreg));
  assign rif.stop_ok   = stop_bit;

  // a whole frame separates two received bytes
  valid_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    valid |=> !valid
  );

endmodule

`default_nettype wire

//--- verilog/uart_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_seq import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 434,
  parameter int GAP_BITS     = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  read_rdy,
  output logic [READ_WIDTH-1:0] read_data,
  uart_tx_if.seq                tif,
  uart_rx_if.seq                rif
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int GAP_W = $clog2(GAP_BITS + 2);

  localparam logic [2:0] S_IDLE   = 3'd0;
  localparam logic [2:0] S_JUDGE  = 3'd1;
  localparam logic [2:0] S_FRAME0 = 3'd2;
  localparam logic [2:0] S_DELAY  = 3'd3;
  localparam logic [2:0] S_FRAME1 = 3'd4;
  localparam logic [2:0] S_RWAIT  = 3'd5;

  logic [2:0]           state;
  logic [CMD_WIDTH-1:0] cmd_buf;
  logic [CNT_W-1:0]     clk_cnt;
  logic [GAP_W-1:0]     gap_cnt;
  logic                 gap_done;
  logic                 issue;
  logic                 rx_good;
  logic [DATA_BITS-1:0] cmd_byte;

  assign cmd_rdy  = (state == S_IDLE);
  assign gap_done = (gap_cnt == GAP_W'(GAP_BITS));
  assign rx_good  = rif.valid && rif.parity_ok && rif.stop_ok;
  assign cmd_byte = {cmd_buf[CMD_WR_BIT], cmd_buf[CMD_ADDR_MSB:CMD_ADDR_LSB]};

  // the command byte goes out from judge, the data byte once the gap has elapsed
  assign issue     = ((state == S_JUDGE) || (state == S_DELAY && gap_done)) && !tif.busy;
  assign tif.start = issue;
  assign tif.data  = (state == S_JUDGE) ? cmd_byte : cmd_buf[DATA_BITS-1:0];

  always_ff @(posedge clk) begin
    if (cmd_vld && cmd_rdy) begin
      cmd_buf <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      clk_cnt   <= '0;
      gap_cnt   <= '0;
      read_rdy  <= 1'b0;
      read_data <= '0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        S_IDLE: begin
          if (cmd_vld) begin
            state <= S_JUDGE;
          end
        end
        S_JUDGE: begin
          if (issue) begin
            state <= S_FRAME0;
          end
        end
        S_FRAME0: begin
          if (tif.done) begin
            // writes still owe the data byte, reads now wait on the rx line
            state   <= cmd_buf[CMD_WR_BIT] ? S_DELAY : S_RWAIT;
            clk_cnt <= '0;
            gap_cnt <= '0;
          end
        end
        S_DELAY: begin
          if (gap_done) begin
            if (issue) begin
              state <= S_FRAME1;
            end
          end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            gap_cnt <= gap_cnt + 1'b1;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        S_FRAME1: begin
          if (tif.done) begin
            state <= S_IDLE;
          end
        end
        S_RWAIT: begin
          // frames with a bad parity or stop bit are dropped and the wait goes on
          if (rx_good) begin
            read_data <= rif.data;
            read_rdy  <= 1'b1;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // the host never hands over a command in the cycle that a read completes
  no_accept_with_read: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(cmd_vld && cmd_rdy && read_rdy)
  );

endmodule

`default_nettype wire

//--- verilog/uart_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_bridge_top import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = 434,
  parameter int GAP_BITS     = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  input  logic                  rx,
  output logic                  tx,
  output logic                  read_rdy,
  output logic [READ_WIDTH-1:0] read_data,
  output logic                  cmd_rdy
);

  uart_tx_if tx_bus ();
  uart_rx_if rx_bus ();

  uart_cmd_seq #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .GAP_BITS     (GAP_BITS)
  ) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .tif       (tx_bus.seq),
    .rif       (rx_bus.seq)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .tif   (tx_bus.tx),
    .tx    (tx)
  );

  // the receiver listens all the time, the sequencer decides what to keep
  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .rif   (rx_bus.rx)
  );

endmodule

`default_nettype wire

//--- testbench/tb_uart_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_bridge import uart_pkg::*; ();

  localparam int CLKS_PER_BIT = 8;
  localparam int GAP_BITS     = 2;
  localparam int CLK_PERIOD   = 20;

  typedef struct {
    logic [CMD_WIDTH-1:0]  cmd;
    int                    mode;
    logic [DATA_BITS-1:0]  resp1;
    logic [DATA_BITS-1:0]  resp2;
    logic [READ_WIDTH-1:0] read;
  } test_t;

  typedef struct {
    logic [DATA_BITS-1:0] data;
    logic                 start;
    logic                 parity;
    logic                 stop;
    longint               t;
  } frame_t;

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  rx;
  logic                  tx;
  logic                  read_rdy;
  logic [READ_WIDTH-1:0] read_data;
  logic                  cmd_rdy;

  test_t                 tests[$];
  frame_t                frames[$];
  bit                    loaded = 1'b0;
  int                    starts = 0;
  int                    rdy_count = 0;
  logic [READ_WIDTH-1:0] rdy_data;
  int                    errors = 0;
  int                    tests_passed = 0;
  int                    tests_failed = 0;
  int                    seed = 63;

  uart_bridge_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .GAP_BITS     (GAP_BITS)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .cmd_rdy   (cmd_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic frame_parity(input logic [DATA_BITS-1:0] b);
    int ones;
    ones = 0;
    for (int i = 0; i < DATA_BITS; i++) begin
      if (b[i]) ones++;
    end
    return (ones % 2) == 1;
  endfunction

  task automatic check_byte(input logic [DATA_BITS-1:0] got, input logic [DATA_BITS-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("Fail %0t ns: %s, expected %h, got %h", $time, what, exp, got);
      errors++;
    end
  endtask

  task automatic check_read(input logic [READ_WIDTH-1:0] got, input logic [READ_WIDTH-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("Fail %0t ns: %s, expected %h, got %h", $time, what, exp, got);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t ns: %s, expected %b, got %b", $time, what, exp, got);
      errors++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("Fail %0t ns: %s, expected %0d, got %0d", $time, what, exp, got);
      errors++;
    end
  endtask

  task automatic load_tests();
    int    fd;
    string line;
    test_t t;
    fd = $fopen("testbench/uart_bridge_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/uart_bridge_tests.txt");
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() > 0 && line[0] != "#" &&
          $sscanf(line, "%h %d %h %h %h", t.cmd, t.mode, t.resp1, t.resp2, t.read) == 5) begin
        tests.push_back(t);
      end
    end
    $fclose(fd);
  endtask

  // samples tx in the middle of every bit, away from the edges where tx moves
  initial begin : tx_monitor
    frame_t f;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge tx);
      f.t = $time;
      starts++;
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      f.start = tx;
      for (int i = 0; i < DATA_BITS; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        f.data[i] = tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      f.parity = tx;
      repeat (CLKS_PER_BIT) @(negedge clk);
      f.stop = tx;
      frames.push_back(f);
    end
  end

  always @(negedge clk) begin
    if (rst_n === 1'b1 && read_rdy === 1'b1) begin
      rdy_count++;
      rdy_data = read_data;
    end
  end

  task automatic send_command(input logic [CMD_WIDTH-1:0] cmd);
    @(posedge clk);
    #2;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(posedge clk);
    #2;
    cmd_vld = 1'b0;
    check_bit(cmd_rdy, 1'b0, "cmd_rdy in the cycle after acceptance");
  endtask

  // a stray command while the bridge is busy has to be ignored
  task automatic pulse_vld_while_busy(input logic [CMD_WIDTH-1:0] cmd);
    repeat (3 * CLKS_PER_BIT) @(posedge clk);
    #2;
    cmd_in  = ~cmd;
    cmd_vld = 1'b1;
    @(posedge clk);
    #2;
    cmd_vld = 1'b0;
  endtask

  task automatic send_rx_frame(input logic [DATA_BITS-1:0] b, input logic bad_parity);
    logic [FRAME_BITS-1:0] bits;
    bits = {1'b1, frame_parity(b) ^ bad_parity, b, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++) begin
      @(posedge clk);
      #2;
      rx = bits[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic idle_bits();
    repeat (($unsigned($random(seed)) % 8) * CLKS_PER_BIT) @(posedge clk);
  endtask

  task automatic answer_read(input test_t t);
    while (frames.size() == 0) @(negedge clk);
    // the monitor finishes at mid stop bit, so let the command frame end first
    repeat (CLKS_PER_BIT) @(posedge clk);
    if (t.mode == 2) begin
      idle_bits();
      send_rx_frame(t.resp1, 1'b1);
    end
    idle_bits();
    send_rx_frame((t.mode == 2) ? t.resp2 : t.resp1, 1'b0);
  endtask

  task automatic check_tx_frame(input int idx, input logic [DATA_BITS-1:0] exp);
    check_bit(frames[idx].start, 1'b0, "tx start bit");
    check_byte(frames[idx].data, exp, "tx frame byte");
    check_bit(frames[idx].parity, frame_parity(exp), "tx parity bit");
    check_bit(frames[idx].stop, 1'b1, "tx stop bit");
  endtask

  task automatic run_test(input int n);
    test_t t;
    logic  is_write;
    int    err_before;
    int    starts_before;
    int    gap_cycles;
    t             = tests[n];
    is_write      = t.cmd[CMD_WR_BIT];
    err_before    = errors;
    starts_before = starts;
    frames.delete();
    rdy_count = 0;
    send_command(t.cmd);
    pulse_vld_while_busy(t.cmd);
    if (!is_write) answer_read(t);
    while (cmd_rdy !== 1'b1) @(negedge clk);
    repeat (2 * CLKS_PER_BIT) @(negedge clk);
    check_tx_frame(0, t.cmd[CMD_WIDTH-1:CMD_WIDTH-DATA_BITS]);
    if (is_write) begin
      check_count(starts - starts_before, 2, "frames sent for a write");
      check_tx_frame(1, t.cmd[DATA_BITS-1:0]);
      // done sits in the last cycle of frame one, then the gap, then two cycles to the line
      gap_cycles = int'((frames[1].t - frames[0].t) / CLK_PERIOD);
      check_count(gap_cycles, FRAME_BITS * CLKS_PER_BIT - 1 + GAP_BITS * CLKS_PER_BIT + 2,
                  "cycles between the two write start bits");
      check_count(rdy_count, 0, "read_rdy pulses during a write");
    end else begin
      check_count(starts - starts_before, 1, "frames sent for a read");
      check_bit(frames[0].data[7], 1'b0, "write flag in the read command byte");
      check_count(rdy_count, 1, "read_rdy pulses during a read");
      check_read(rdy_data, t.read, "read_data with read_rdy");
    end
    check_read(read_data, t.read, "read_data at the end of the test");
    check_bit(cmd_rdy, 1'b1, "cmd_rdy after the command");
    if (errors == err_before) tests_passed++;
    else tests_failed++;
    $display("test %0d: %s %h, %0d errors", n, is_write ? "write" : "read", t.cmd,
             errors - err_before);
  endtask

  initial begin : watchdog
    longint limit;
    wait (loaded);
    limit = longint'(tests.size() + 1) * 40 * FRAME_BITS * CLKS_PER_BIT * CLK_PERIOD;
    #(limit);
    $display("timeout: the bridge did not finish the tests within %0d ns", limit);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    load_tests();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (2 * CLKS_PER_BIT) @(negedge clk);
    check_bit(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_bit(read_rdy, 1'b0, "read_rdy after reset");
    check_bit(tx, 1'b1, "tx idle after reset");
    check_count(starts, 0, "frames before any command");
    if (tests.size() == 0) begin
      $display("no tests were read from the data file");
      errors++;
    end
    foreach (tests[i]) run_test(i);
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/uart_bridge_tests.txt
# cmd mode resp1 resp2 read: cmd and bytes in hex, read is the expected read_data
# mode 0 no rx response, 1 one good frame, 2 bad parity frame then a good frame
8A5C 0 00 00 00
0A00 1 3C 00 3C
FF01 0 00 00 3C
1112 2 55 A7 A7
8000 0 00 00 A7
7F00 1 00 00 00
81FF 0 00 00 00
2200 1 FF 00 FF
23C4 2 96 69 69
C3AA 0 00 00 69
9155 0 00 00 69
4400 1 81 00 81
0100 2 00 7E 7E
E6E6 0 00 00 7E
5A00 1 C3 00 C3
8F0F 0 00 00 C3
3300 1 01 00 01
6600 2 FE 80 80

//--- flist.f
verilog/uart_pkg.sv
verilog/uart_tx_if.sv
verilog/uart_rx_if.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_cmd_seq.sv
verilog/uart_bridge_top.sv
testbench/tb_uart_bridge.sv
